//--- include/ifill_params.svh
// L1.5 message codes and fill line geometry, included by the package, the RTL and the testbench
`ifndef IFILL_PARAMS_SVH
`define IFILL_PARAMS_SVH

// Return type of an instruction fill coming back from the L1.5
`define IFILL_RET 4'd1

// Return type of an interrupt packet, which carries the wake code in data_0
`define INT_RET 4'd7

// Request type sent to the L1.5 for an instruction miss
`define IMISS_RQ 5'd16

// Size code for a 4-byte access, the only size the fetch path issues
`define PCX_SZ_4B 3'd2

// Low address bits cleared so the miss address is line aligned
`define LINE_OFFSET_BITS 5

// A fill carries four 32-bit instruction words
`define FILL_WORDS 4

// Lowest bit of the 2-bit wake field in the interrupt word
`define WAKE_FIELD_LSB 16

// Value of the wake field that releases the core
`define WAKE_CODE 2'd1

`endif

//--- rtl/ifill_pkg.sv
// Shared word, line and address types for the fetch bridge RTL and its testbench
`include "ifill_params.svh"

package ifill_pkg;

    // Byte address as seen by the x86 core
    typedef logic [31:0] core_addr_t;

    // Physical address on the L1.5 request side
    typedef logic [39:0] l15_addr_t;

    // One instruction word in little-endian byte order
    typedef logic [31:0] fetch_word_t;

    // Captured fill line, index 0 is the first word handed to the core
    typedef fetch_word_t [`FILL_WORDS-1:0] fill_line_t;

    // One raw 64-bit half of an L1.5 return, big-endian
    typedef logic [63:0] l15_data_t;

endpackage

//--- rtl/fill_word_if.sv
// Carries a captured fill line and its valid pulse from the fill buffer to the streamer and issuer
`timescale 1ns/1ps

interface fill_word_if;
    import ifill_pkg::*;

    // High for one cycle after a fill has been captured
    logic fill_valid;

    // The four little-endian words of the captured line
    fill_line_t words;

    // The buffer owns both signals
    modport buffer (
        output fill_valid,
        output words
    );

    // The streamer hands the words to the core once the pulse arrives
    modport streamer (
        input fill_valid,
        input words
    );

    // The issuer only needs to know that the outstanding miss has completed
    modport issuer (
        input fill_valid
    );

endinterface

//--- rtl/miss_issuer.sv
// Wakes the core on an interrupt return and issues one instruction-miss request at a time to the L1.5
`timescale 1ns/1ps
`include "ifill_params.svh"

module miss_issuer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 request_readcode_do,
    input  ifill_pkg::core_addr_t request_readcode_address,
    input  logic                 l15_val,
    input  logic [3:0]           l15_returntype,
    input  ifill_pkg::l15_data_t  l15_data_0,
    input  logic                 l15_header_ack,
    fill_word_if.issuer          fill,
    output logic                 awake,
    output logic                 l15_req_val,
    output logic [4:0]           l15_rqtype,
    output ifill_pkg::l15_addr_t  l15_address,
    output logic [2:0]           l15_size
);
    import ifill_pkg::*;

    // Number of sign bits added when widening a core address to the L1.5 width
    localparam int EXT_BITS = $bits(l15_addr_t) - $bits(core_addr_t);

    logic       wake_hit;
    logic       outstanding;
    logic       accept;
    l15_addr_t  miss_address;

    // An interrupt return wakes the core only when its wake field holds the wake code
    assign wake_hit = l15_val
                   && (l15_returntype == `INT_RET)
                   && (l15_data_0[`WAKE_FIELD_LSB +: 2] == `WAKE_CODE);

    // A fetch is taken only once the core runs and no miss is in flight
    assign accept = request_readcode_do && awake && !outstanding;

    // Clear the line offset and sign-extend to the L1.5 address width
    assign miss_address = {
        {EXT_BITS{request_readcode_address[$bits(core_addr_t)-1]}},
        request_readcode_address[$bits(core_addr_t)-1:`LINE_OFFSET_BITS],
        {`LINE_OFFSET_BITS{1'b0}}
    };

    // Wake register, sticky until the next reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awake <= 1'b0;
        end else if (wake_hit) begin
            awake <= 1'b1;
        end
    end

    // Outstanding miss tracking
    // The miss stays open from acceptance until the buffer reports the fill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
            l15_req_val <= 1'b0;
            l15_rqtype  <= 5'd0;
            l15_address <= '0;
        end else if (accept) begin
            outstanding <= 1'b1;
            l15_req_val <= 1'b1;
            l15_rqtype  <= `IMISS_RQ;
            l15_address <= miss_address;
        end else begin
            // The request is held until the L1.5 takes the header
            if (l15_req_val && l15_header_ack) begin
                l15_req_val <= 1'b0;
            end
            // Address and type stay visible until the line comes back
            if (fill.fill_valid) begin
                outstanding <= 1'b0;
                l15_rqtype  <= 5'd0;
                l15_address <= '0;
            end
        end
    end

    // The core only ever fetches whole words, so the size is constant once awake
    assign l15_size = awake ? `PCX_SZ_4B : 3'd0;

endmodule

//--- rtl/fill_line_buffer.sv
// Captures an instruction-fill return from the L1.5 and stores it as four little-endian words
`timescale 1ns/1ps
`include "ifill_params.svh"

module fill_line_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                l15_val,
    input  logic [3:0]          l15_returntype,
    input  ifill_pkg::l15_data_t l15_data_2,
    input  ifill_pkg::l15_data_t l15_data_3,
    fill_word_if.buffer         fill
);
    import ifill_pkg::*;

    logic capture;

    // Reverse the byte order of one 32-bit word
    function automatic fetch_word_t byte_swap(input fetch_word_t be_word);
        fetch_word_t le_word;
        for (int b = 0; b < 4; b++) begin
            le_word[8*b +: 8] = be_word[8*(3-b) +: 8];
        end
        return le_word;
    endfunction

    // Only instruction fills are of interest, every other return passes by
    assign capture = l15_val && (l15_returntype == `IFILL_RET);

    // Line storage
    // The upper half of each 64-bit return word holds the earlier instruction word
    always_ff @(posedge clk) begin
        if (capture) begin
            fill.words[0] <= byte_swap(l15_data_2[63:32]);
            fill.words[1] <= byte_swap(l15_data_2[31:0]);
            fill.words[2] <= byte_swap(l15_data_3[63:32]);
            fill.words[3] <= byte_swap(l15_data_3[31:0]);
        end
    end

    // Tell the streamer and issuer one cycle after the capture edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill.fill_valid <= 1'b0;
        end else begin
            fill.fill_valid <= capture;
        end
    end

endmodule

//--- rtl/fetch_word_streamer.sv
// Hands a captured fill line to the core one word per cycle and builds up the full line as it goes
`timescale 1ns/1ps
`include "ifill_params.svh"

module fetch_word_streamer (
    input  logic                   clk,
    input  logic                   rst_n,
    fill_word_if.streamer          fill,
    output ifill_pkg::fetch_word_t readcode_partial,
    output logic [127:0]           readcode_line,
    output logic                   readcode_partial_done,
    output logic                   readcode_done
);
    import ifill_pkg::*;

    localparam int WORD_BITS = $bits(fetch_word_t);
    localparam int LINE_BITS = `FILL_WORDS * WORD_BITS;
    localparam logic [1:0] LAST_WORD = 2'(`FILL_WORDS - 1);

    logic       active;
    logic [1:0] word_idx;

    // Word streaming
    // Word 0 goes out on the edge that sees fill_valid, the rest follow on the
    // next three edges with word 0 kept in the top bits of the line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active                <= 1'b0;
            word_idx              <= 2'd0;
            readcode_partial      <= '0;
            readcode_line         <= '0;
            readcode_partial_done <= 1'b0;
            readcode_done         <= 1'b0;
        end else begin
            // Strobes are single-cycle by default
            readcode_partial_done <= 1'b0;
            readcode_done         <= 1'b0;

            if (fill.fill_valid) begin
                active                <= 1'b1;
                word_idx              <= 2'd1;
                readcode_partial      <= fill.words[0];
                readcode_line         <= {fill.words[0], {(LINE_BITS-WORD_BITS){1'b0}}};
                readcode_partial_done <= 1'b1;
            end else if (active) begin
                readcode_partial <= fill.words[word_idx];
                readcode_line[LINE_BITS-1 - WORD_BITS*int'(word_idx) -: WORD_BITS]
                    <= fill.words[word_idx];
                word_idx <= word_idx + 2'd1;

                // The last word closes the line, all others are partial
                if (word_idx == LAST_WORD) begin
                    readcode_done <= 1'b1;
                    active        <= 1'b0;
                end else begin
                    readcode_partial_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/ifill_transducer.sv
// Top level of the fetch bridge between the x86 core and the L1.5, wiring issuer, buffer and streamer
`timescale 1ns/1ps

module ifill_transducer (
    input  logic                   clk,
    input  logic                   rst_n,

    // Requests toward the L1.5
    output logic [4:0]             transducer_l15_rqtype,
    output ifill_pkg::l15_addr_t    transducer_l15_address,
    output logic                   transducer_l15_val,
    output logic                   transducer_l15_req_ack,
    output logic [2:0]             transducer_l15_size,

    // Returns from the L1.5
    input  logic                   l15_transducer_val,
    input  logic [3:0]             l15_transducer_returntype,
    input  logic                   l15_transducer_header_ack,
    input  ifill_pkg::l15_data_t    l15_transducer_data_0,
    input  ifill_pkg::l15_data_t    l15_transducer_data_2,
    input  ifill_pkg::l15_data_t    l15_transducer_data_3,

    // Fetch requests from the core
    input  logic                   request_readcode_do,
    input  ifill_pkg::core_addr_t   request_readcode_address,

    // Fetch responses and wake-up toward the core
    output ifill_pkg::fetch_word_t  transducer_ao486_readcode_partial,
    output logic [127:0]           transducer_ao486_readcode_line,
    output logic                   transducer_ao486_request_readcode_done,
    output logic                   transducer_ao486_readcode_partial_done,
    output logic                   ao486_int
);

    // Captured line shared by the three blocks
    fill_word_if fill_bus ();

    miss_issuer u_issuer (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .request_readcode_do      (request_readcode_do),
        .request_readcode_address (request_readcode_address),
        .l15_val                  (l15_transducer_val),
        .l15_returntype           (l15_transducer_returntype),
        .l15_data_0               (l15_transducer_data_0),
        .l15_header_ack           (l15_transducer_header_ack),
        .fill                     (fill_bus.issuer),
        .awake                    (ao486_int),
        .l15_req_val              (transducer_l15_val),
        .l15_rqtype               (transducer_l15_rqtype),
        .l15_address              (transducer_l15_address),
        .l15_size                 (transducer_l15_size)
    );

    fill_line_buffer u_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .l15_val        (l15_transducer_val),
        .l15_returntype (l15_transducer_returntype),
        .l15_data_2     (l15_transducer_data_2),
        .l15_data_3     (l15_transducer_data_3),
        .fill           (fill_bus.buffer)
    );

    fetch_word_streamer u_streamer (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .fill                  (fill_bus.streamer),
        .readcode_partial      (transducer_ao486_readcode_partial),
        .readcode_line         (transducer_ao486_readcode_line),
        .readcode_partial_done (transducer_ao486_readcode_partial_done),
        .readcode_done         (transducer_ao486_request_readcode_done)
    );

    // Every L1.5 return is taken in the cycle it is offered
    assign transducer_l15_req_ack = l15_transducer_val;

endmodule

//--- bench/ifill_properties.sv
// Concurrent protocol checks on the fetch bridge, attached to the top level by bind
`timescale 1ns/1ps
`include "ifill_params.svh"

module ifill_properties (
    input logic         clk,
    input logic         rst_n,
    input logic         transducer_l15_val,
    input logic         l15_transducer_header_ack,
    input logic [4:0]   transducer_l15_rqtype,
    input logic [39:0]  transducer_l15_address,
    input logic [2:0]   transducer_l15_size,
    input logic [31:0]  transducer_ao486_readcode_partial,
    input logic [127:0] transducer_ao486_readcode_line,
    input logic         transducer_ao486_request_readcode_done,
    input logic         transducer_ao486_readcode_partial_done,
    input logic         ao486_int
);

    // The request header stays up until the L1.5 takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        transducer_l15_val && !l15_transducer_header_ack |=> transducer_l15_val)
        else $error("request valid dropped before the header was acknowledged");

    // Only instruction misses are ever issued
    assert property (@(posedge clk) disable iff (!rst_n)
        transducer_l15_val |-> transducer_l15_rqtype == `IMISS_RQ)
        else $error("request type is not an instruction miss");

    // Last word and partial word strobes are exclusive
    assert property (@(posedge clk) disable iff (!rst_n)
        !(transducer_ao486_request_readcode_done && transducer_ao486_readcode_partial_done))
        else $error("done and partial done high together");

    // A sleeping core sees no fetch activity and issues nothing
    assert property (@(posedge clk) disable iff (!rst_n)
        !ao486_int |-> (!transducer_l15_val && transducer_l15_rqtype == '0
            && transducer_l15_address == '0 && transducer_l15_size == '0
            && transducer_ao486_readcode_partial == '0 && transducer_ao486_readcode_line == '0
            && !transducer_ao486_request_readcode_done
            && !transducer_ao486_readcode_partial_done))
        else $error("output active while the core is asleep");

endmodule

bind ifill_transducer ifill_properties u_props (
    .clk                                    (clk),
    .rst_n                                  (rst_n),
    .transducer_l15_val                     (transducer_l15_val),
    .l15_transducer_header_ack              (l15_transducer_header_ack),
    .transducer_l15_rqtype                  (transducer_l15_rqtype),
    .transducer_l15_address                 (transducer_l15_address),
    .transducer_l15_size                    (transducer_l15_size),
    .transducer_ao486_readcode_partial      (transducer_ao486_readcode_partial),
    .transducer_ao486_readcode_line         (transducer_ao486_readcode_line),
    .transducer_ao486_request_readcode_done (transducer_ao486_request_readcode_done),
    .transducer_ao486_readcode_partial_done (transducer_ao486_readcode_partial_done),
    .ao486_int                              (ao486_int)
);

//--- bench/tb_ifill_transducer.sv
// Self-checking testbench for the fetch bridge; run it as the simulation top with the bound properties
`timescale 1ns/1ps
`include "ifill_params.svh"

module tb_ifill_transducer;
    import ifill_pkg::*;

    // Each miss needs well under 40 cycles and the margin covers reset and the wake-up phase
    localparam int NUM_TXN     = 8;
    localparam int CYCLE_LIMIT = 16 + 40 * NUM_TXN + 200;

    logic         clk;
    logic         rst_n;
    logic [4:0]   transducer_l15_rqtype;
    l15_addr_t    transducer_l15_address;
    logic         transducer_l15_val;
    logic         transducer_l15_req_ack;
    logic [2:0]   transducer_l15_size;
    logic         l15_transducer_val;
    logic [3:0]   l15_transducer_returntype;
    logic         l15_transducer_header_ack;
    l15_data_t    l15_transducer_data_0;
    l15_data_t    l15_transducer_data_2;
    l15_data_t    l15_transducer_data_3;
    logic         request_readcode_do;
    core_addr_t   request_readcode_address;
    fetch_word_t  transducer_ao486_readcode_partial;
    logic [127:0] transducer_ao486_readcode_line;
    logic         transducer_ao486_request_readcode_done;
    logic         transducer_ao486_readcode_partial_done;
    logic         ao486_int;

    logic [31:0]  rng_state;
    int           error_count;
    int           cycle_count;
    int           words_seen;
    int           words_checked;
    int           fills_seen;
    // Raw halves of the fill in flight that the compare process checks against
    l15_data_t    exp_data_2;
    l15_data_t    exp_data_3;

    ifill_transducer u_dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Word idx is the idx-th big-endian 32-bit slice of {data_2, data_3} with its bytes reversed
    function automatic fetch_word_t expected_word(input l15_data_t d2, input l15_data_t d3,
                                                  input int idx);
        logic [127:0] raw;
        logic [31:0]  be;
        raw = {d2, d3};
        be = raw[127 - 32*idx -: 32];
        return {be[7:0], be[15:8], be[23:16], be[31:24]};
    endfunction

    // Line-aligned core address widened with its sign bit
    function automatic l15_addr_t expected_address(input core_addr_t a);
        core_addr_t aligned;
        aligned = a & ~((32'd1 << `LINE_OFFSET_BITS) - 32'd1);
        return {{8{aligned[31]}}, aligned};
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        error_count++;
        $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic print_summary();
        $display("Errors: %0d, words checked: %0d, fills completed: %0d of %0d",
                 error_count, words_checked, fills_seen, NUM_TXN);
    endtask

    // One-cycle fetch request from the core that ends on the next falling edge
    task automatic pulse_request(input core_addr_t addr);
        request_readcode_do      = 1'b1;
        request_readcode_address = addr;
        @(negedge clk);
        request_readcode_do      = 1'b0;
    endtask

    // One-cycle L1.5 return packet
    task automatic drive_return(input logic [3:0] rtype, input l15_data_t d0,
                                input l15_data_t d2, input l15_data_t d3);
        l15_transducer_val        = 1'b1;
        l15_transducer_returntype = rtype;
        l15_transducer_data_0     = d0;
        l15_transducer_data_2     = d2;
        l15_transducer_data_3     = d3;
        @(negedge clk);
        l15_transducer_val        = 1'b0;
    endtask

    // One miss with the L1.5 model acking and filling after random delays
    task automatic run_miss(input int txn);
        core_addr_t addr;
        l15_addr_t  exp_addr;
        int         ack_delay;
        int         fill_delay;
        addr       = next_rand();
        exp_addr   = expected_address(addr);
        ack_delay  = next_rand() % 4;
        fill_delay = 1 + next_rand() % 4;
        if (transducer_l15_val !== 1'b0)
            report_mismatch("transducer_l15_val", 1'b0, transducer_l15_val);
        pulse_request(addr);
        if (transducer_l15_val !== 1'b1)
            report_mismatch("transducer_l15_val", 1'b1, transducer_l15_val);
        if (transducer_l15_address !== exp_addr)
            report_mismatch("transducer_l15_address", exp_addr, transducer_l15_address);
        if (transducer_l15_rqtype !== `IMISS_RQ)
            report_mismatch("transducer_l15_rqtype", `IMISS_RQ, transducer_l15_rqtype);
        if (transducer_l15_size !== `PCX_SZ_4B)
            report_mismatch("transducer_l15_size", `PCX_SZ_4B, transducer_l15_size);
        // The header is held until the L1.5 model takes it
        repeat (ack_delay) begin
            @(negedge clk);
            if (transducer_l15_val !== 1'b1)
                report_mismatch("transducer_l15_val", 1'b1, transducer_l15_val);
        end
        l15_transducer_header_ack = 1'b1;
        @(negedge clk);
        l15_transducer_header_ack = 1'b0;
        if (transducer_l15_val !== 1'b0)
            report_mismatch("transducer_l15_val", 1'b0, transducer_l15_val);
        // A request while the miss is open must be dropped
        if (txn % 2 == 1) begin
            pulse_request(~addr);
            if (transducer_l15_val !== 1'b0)
                report_mismatch("transducer_l15_val", 1'b0, transducer_l15_val);
        end
        repeat (fill_delay) @(negedge clk);
        if (transducer_l15_address !== exp_addr)
            report_mismatch("transducer_l15_address", exp_addr, transducer_l15_address);
        exp_data_2 = {next_rand(), next_rand()};
        exp_data_3 = {next_rand(), next_rand()};
        drive_return(`IFILL_RET, '0, exp_data_2, exp_data_3);
        // Wait until the compare process has seen the last word of this fill
        while (fills_seen < txn + 1) @(negedge clk);
    endtask

    // Compare process for the core-side stream and the response acknowledge
    always @(posedge clk) begin : compare_stream
        logic [127:0] exp_line;
        if (rst_n) begin
            if (transducer_l15_req_ack !== l15_transducer_val)
                report_mismatch("transducer_l15_req_ack", l15_transducer_val,
                                transducer_l15_req_ack);
            if (transducer_ao486_readcode_partial_done || transducer_ao486_request_readcode_done)
            begin
                if (transducer_ao486_readcode_partial
                        !== expected_word(exp_data_2, exp_data_3, words_seen))
                    report_mismatch("transducer_ao486_readcode_partial",
                                    expected_word(exp_data_2, exp_data_3, words_seen),
                                    transducer_ao486_readcode_partial);
                // Words received so far sit in the top of the line and the rest is zero
                exp_line = '0;
                for (int i = 0; i <= words_seen; i++) begin
                    exp_line[127 - 32*i -: 32] = expected_word(exp_data_2, exp_data_3, i);
                end
                if (transducer_ao486_readcode_line !== exp_line)
                    report_mismatch("transducer_ao486_readcode_line", exp_line,
                                    transducer_ao486_readcode_line);
                if (transducer_ao486_request_readcode_done !== (words_seen == `FILL_WORDS - 1))
                    report_mismatch("transducer_ao486_request_readcode_done",
                                    words_seen == `FILL_WORDS - 1,
                                    transducer_ao486_request_readcode_done);
                if (transducer_ao486_readcode_partial_done !== (words_seen < `FILL_WORDS - 1))
                    report_mismatch("transducer_ao486_readcode_partial_done",
                                    words_seen < `FILL_WORDS - 1,
                                    transducer_ao486_readcode_partial_done);
                words_checked++;
                if (words_seen == `FILL_WORDS - 1) begin
                    words_seen = 0;
                    fills_seen++;
                end else begin
                    words_seen++;
                end
            end else if (words_seen != 0) begin
                // Once a stream has started the core gets one word in every cycle
                report_problem("the fetch stream paused before its last word");
            end
        end
    end

    // Cycle limit for a stuck handshake or a stream that never ends
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the fill stream never completed", cycle_count);
            print_summary();
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        l15_data_t int_word;
        clk                       = 1'b0;
        rst_n                     = 1'b0;
        l15_transducer_val        = 1'b0;
        l15_transducer_returntype = 4'd0;
        l15_transducer_header_ack = 1'b0;
        l15_transducer_data_0     = '0;
        l15_transducer_data_2     = '0;
        l15_transducer_data_3     = '0;
        request_readcode_do       = 1'b0;
        request_readcode_address  = '0;
        rng_state                 = 32'hf6e5_478c;
        error_count               = 0;
        cycle_count               = 0;
        words_seen                = 0;
        words_checked             = 0;
        fills_seen                = 0;
        exp_data_2                = '0;
        exp_data_3                = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // Fetches while the core sleeps must not reach the L1.5
        pulse_request(next_rand());
        repeat (3) begin
            if (transducer_l15_val !== 1'b0)
                report_mismatch("transducer_l15_val", 1'b0, transducer_l15_val);
            if (ao486_int !== 1'b0)
                report_mismatch("ao486_int", 1'b0, ao486_int);
            @(negedge clk);
        end

        // An interrupt with another wake field keeps the core asleep
        int_word = '0;
        int_word[`WAKE_FIELD_LSB +: 2] = 2'd2;
        drive_return(`INT_RET, int_word, '0, '0);
        @(negedge clk);
        if (ao486_int !== 1'b0)
            report_mismatch("ao486_int", 1'b0, ao486_int);

        // The wake code releases the core at the sampling edge
        int_word[`WAKE_FIELD_LSB +: 2] = `WAKE_CODE;
        drive_return(`INT_RET, int_word, '0, '0);
        if (ao486_int !== 1'b1)
            report_mismatch("ao486_int", 1'b1, ao486_int);

        for (int t = 0; t < NUM_TXN; t++) begin
            run_miss(t);
        end
        // The quiet cycles after the last fill carry no further fetch strobe
        repeat (5) @(negedge clk);
        if (words_seen != 0 || fills_seen != NUM_TXN)
            report_problem("a fetch strobe arrived after the last fill had completed");

        print_summary();
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- ifill_transducer.f
+incdir+include
rtl/ifill_pkg.sv
rtl/fill_word_if.sv
rtl/miss_issuer.sv
rtl/fill_line_buffer.sv
rtl/fetch_word_streamer.sv
rtl/ifill_transducer.sv
bench/ifill_properties.sv
bench/tb_ifill_transducer.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
verilator --binary --timing --assert -Wno-fatal -f ifill_transducer.f \
    --top-module tb_ifill_transducer -o tb_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Run failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run ended without a result, see sim.log"; exit 1; }
exit 0
